// ==== files.f ====
+incdir+design
design/ddr_ctrl_pkg.sv
design/cmd_queue.sv
design/app_sequencer.sv
design/read_return.sv
design/ddr_ctrl_top.sv
tests/tb_clock_gen.sv
tests/app_mem_model.sv
tests/tb_ddr_ctrl.sv

// ==== Makefile ====
TOP := tb_ddr_ctrl
LOG := sim.log

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -o $(TOP)

run:
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_ddr_ctrl.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module tb_ddr_ctrl;
    import ddr_ctrl_pkg::*;

    logic clk_if;
    logic resetn;
    ddr_req_t  req;
    logic      req_valid;
    logic      req_ready;
    ddr_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;
    app_cmd_t  app_cmd;
    logic      app_cmd_en;
    logic      app_cmd_ready;
    logic [`DDR_ADDR_WIDTH-1:0] app_addr;
    logic [`DDR_DATA_WIDTH-1:0] app_wr_data;
    logic      app_wr_data_en;
    logic [`DDR_STRB_WIDTH-1:0] app_wr_data_mask;
    logic      app_wr_data_rdy;
    logic [`DDR_DATA_WIDTH-1:0] app_rd_data;
    logic      app_rd_data_valid;
    logic      stall_cmd;
    logic      stall_wr;
    logic [2:0] rd_delay;

    logic [31:0] env_lfsr  = 32'h2d9e_66d7;
    logic [31:0] stim_lfsr = 32'h2d9e_66d7;
    logic [63:0] ref_mem [256];
    ddr_resp_t   exp_mem [1024];  // expected responses, ring
    ddr_resp_t   exp_head;
    int          exp_wr;
    int          exp_rd;
    int          err_cnt;
    int          tests_failed;
    int          resp_mode;  // 0 ready, 1 held low, 2 random
    logic        stall_en;
    ddr_req_t    pend;

    assign exp_head = exp_mem[exp_rd % 1024];

    tb_clock_gen u_clk (.clk_if(clk_if), .resetn(resetn));

    ddr_ctrl_top uut (.*);

    app_mem_model u_mem (.*);

    function automatic logic [63:0] take_bits(inout logic [31:0] s, input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
            v = {v[62:0], s[0]};
        end
        return v;
    endfunction

    always @(posedge clk_if) begin : env
        logic [63:0] r;
        if (!resetn) begin
            resp_ready <= 1'b0;
            stall_cmd  <= 1'b0;
            stall_wr   <= 1'b0;
            rd_delay   <= 3'd2;
        end else begin
            r = take_bits(env_lfsr, 5);
            resp_ready <= (resp_mode == 0) || (resp_mode == 2 && r[0]);
            stall_cmd  <= stall_en && r[1];
            stall_wr   <= stall_en && r[2];
            rd_delay   <= 3'd2 + 3'(r[4:3]);  // 2 to 5 cycles
        end
    end

    always @(posedge clk_if) begin
        if (resetn && resp_valid && resp_ready) exp_rd <= exp_rd + 1;
    end

    a_resp_match: assert property (@(posedge clk_if) disable iff (!resetn)
        resp_valid && resp_ready |-> exp_wr != exp_rd && resp == exp_head)
        else begin
            $display("[ERROR] %0t response id %0h data %h last %0b, expected id %0h data %h last %0b",
                     $time, $sampled(resp.id), $sampled(resp.data), $sampled(resp.last),
                     $sampled(exp_head.id), $sampled(exp_head.data), $sampled(exp_head.last));
            err_cnt++;
        end

    a_resp_hold: assert property (@(posedge clk_if) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            $display("[ERROR] %0t response changed before it was taken", $time);
            err_cnt++;
        end

    function automatic ddr_req_t mk(req_op_t op, logic [3:0] id, logic [27:0] addr,
                                    logic [63:0] data, logic [7:0] strb, logic last);
        return '{op: op, id: id, addr: addr, wdata: data, strb: strb, last: last};
    endfunction

    task automatic record(input ddr_req_t r);
        if (r.op == OP_READ) begin
            exp_mem[exp_wr % 1024] = '{id: r.id, data: ref_mem[r.addr[7:0]], last: r.last};
            exp_wr++;
        end else begin
            for (int b = 0; b < 8; b++) begin
                if (r.strb[b]) ref_mem[r.addr[7:0]][8*b +: 8] = r.wdata[8*b +: 8];
            end
        end
    endtask

    task automatic offer(input ddr_req_t r);  // call right after a rising edge
        pend = r;
        req       <= r;
        req_valid <= 1'b1;
    endtask

    task automatic wait_accept(input int max_wait, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < max_wait) begin
            @(negedge clk_if);
            ok = req_ready;
            n++;
        end
        if (ok) begin
            @(posedge clk_if);  // transfer edge
            record(pend);
        end
    endtask

    task automatic send(input ddr_req_t r);
        logic ok;
        offer(r);
        wait_accept(300, ok);
        if (!ok) begin
            $display("request with id %0h was never accepted", r.id);
            err_cnt++;
        end
    endtask

    task automatic drain(input int max_wait);
        int n;
        n = 0;
        req_valid <= 1'b0;
        while (exp_rd != exp_wr && n < max_wait) begin
            @(negedge clk_if);
            n++;
        end
        if (exp_rd != exp_wr) begin
            $display("%0d responses still missing after %0d cycles", exp_wr - exp_rd, max_wait);
            err_cnt++;
        end
        @(posedge clk_if);
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin : main
        int   e;
        int   i;
        int   n;
        logic ok;
        logic stalled;
        ddr_req_t r;
        req       = '0;
        req_valid = 1'b0;
        resp_ready = 1'b0;
        stall_cmd = 1'b0;
        stall_wr  = 1'b0;
        rd_delay  = 3'd2;
        exp_wr = 0;
        exp_rd = 0;
        err_cnt = 0;
        tests_failed = 0;
        resp_mode = 0;
        stall_en = 1'b0;
        for (int k = 0; k < 256; k++) ref_mem[k] = {8{8'(k)}} ^ 64'h0706_0504_0302_0100;
        n = 0;
        while (!resetn && n < 20) begin
            @(posedge clk_if);
            n++;
        end
        if (!resetn) begin
            $display("reset never released");
            err_cnt++;
        end
        @(posedge clk_if);

        e = err_cnt;
        send(mk(OP_WRITE, 4'h1, 28'h10, 64'hdead_beef_0123_4567, 8'hff, 1'b0));
        send(mk(OP_READ, 4'h2, 28'h10, '0, '0, 1'b1));
        drain(100);
        report("test 1 write then read", e);

        e = err_cnt;
        send(mk(OP_WRITE, 4'h3, 28'h20, 64'h1111_2222_3333_4444, 8'hff, 1'b0));
        send(mk(OP_WRITE, 4'h4, 28'h20, 64'haaaa_bbbb_cccc_dddd, 8'h5a, 1'b0));
        send(mk(OP_READ, 4'h5, 28'h20, '0, '0, 1'b0));
        drain(100);
        report("test 2 partial strobe merge", e);

        e = err_cnt;
        for (int k = 0; k < 6; k++) send(mk(OP_READ, 4'(k + 6), 28'(k), '0, '0, k == 5));
        drain(200);
        report("test 3 back-to-back reads", e);

        e = err_cnt;
        resp_mode <= 1;
        stalled = 1'b0;
        i = 0;
        while (i < 10 && !stalled) begin
            offer(mk(OP_READ, 4'(i), 28'(i * 3), '0, '0, i[0]));
            wait_accept(30, ok);
            if (ok) i++;
            else stalled = 1'b1;
        end
        if (!stalled) begin
            $display("req_ready never fell while responses were blocked");
            err_cnt++;
        end
        resp_mode <= 0;
        if (stalled) begin
            wait_accept(300, ok);
            if (!ok) begin
                $display("stalled request was never accepted after resp_ready rose");
                err_cnt++;
            end
            i++;
            while (i < 10) begin
                send(mk(OP_READ, 4'(i), 28'(i * 3), '0, '0, i[0]));
                i++;
            end
        end
        drain(300);
        report("test 4 response back-pressure", e);

        e = err_cnt;
        resp_mode <= 2;
        stall_en  <= 1'b1;
        for (int k = 0; k < 200; k++) begin
            r.op    = req_op_t'(take_bits(stim_lfsr, 1));
            r.id    = 4'(take_bits(stim_lfsr, 4));
            r.addr  = 28'(take_bits(stim_lfsr, 6));  // small range for address reuse
            r.wdata = take_bits(stim_lfsr, 64);
            r.strb  = 8'(take_bits(stim_lfsr, 8));
            r.last  = take_bits(stim_lfsr, 1) != 0;
            send(r);
        end
        drain(3000);
        resp_mode <= 0;
        stall_en  <= 1'b0;
        report("test 5 random traffic", e);

        $display("tests failed %0d of 5, errors %0d", tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #1_000_000;
        $display("simulation ran past its time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end
endmodule

// ==== tests/app_mem_model.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module app_mem_model (
    input  logic                       clk_if,
    input  logic                       resetn,
    input  ddr_ctrl_pkg::app_cmd_t     app_cmd,
    input  logic                       app_cmd_en,
    input  logic [`DDR_ADDR_WIDTH-1:0] app_addr,
    output logic                       app_cmd_ready,
    input  logic [`DDR_DATA_WIDTH-1:0] app_wr_data,
    input  logic                       app_wr_data_en,
    input  logic [`DDR_STRB_WIDTH-1:0] app_wr_data_mask,
    output logic                       app_wr_data_rdy,
    output logic [`DDR_DATA_WIDTH-1:0] app_rd_data,
    output logic                       app_rd_data_valid,
    input  logic                       stall_cmd,
    input  logic                       stall_wr,
    input  logic [2:0]                 rd_delay
);
    import ddr_ctrl_pkg::*;

    logic [63:0] mem [256];
    logic [63:0] rd_data_q [$];
    int          rd_due_q [$];
    int          cycle;
    int          last_due;
    logic        have_waddr;
    logic        have_wdata;
    logic [7:0]  waddr;
    logic [63:0] wdata;
    logic [7:0]  wmask;

    assign app_cmd_ready   = !stall_cmd;
    assign app_wr_data_rdy = !stall_wr;

    initial begin
        app_rd_data_valid = 1'b0;
        app_rd_data       = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8{8'(i)}} ^ 64'h0706_0504_0302_0100;  // same fill as the tb
        end
    end

    always @(posedge clk_if) begin : model
        int due;
        if (!resetn) begin
            cycle             = 0;
            last_due          = 0;
            have_waddr        = 1'b0;
            have_wdata        = 1'b0;
            app_rd_data_valid <= 1'b0;
            app_rd_data       <= '0;
        end else begin
            cycle = cycle + 1;
            if (app_cmd_en && app_cmd_ready) begin
                if (app_cmd == APP_READ) begin
                    due = cycle + int'(rd_delay);
                    if (due <= last_due) due = last_due + 1;  // keep beats in order
                    last_due = due;
                    rd_data_q.push_back(mem[app_addr[7:0]]);
                    rd_due_q.push_back(due);
                end else begin
                    have_waddr = 1'b1;
                    waddr      = app_addr[7:0];
                end
            end
            if (app_wr_data_en && app_wr_data_rdy) begin
                have_wdata = 1'b1;
                wdata      = app_wr_data;
                wmask      = app_wr_data_mask;
            end
            if (have_waddr && have_wdata) begin
                for (int b = 0; b < 8; b++) begin
                    if (!wmask[b]) mem[waddr][8*b +: 8] = wdata[8*b +: 8];
                end
                have_waddr = 1'b0;
                have_wdata = 1'b0;
            end
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                app_rd_data       <= rd_data_q.pop_front();
                app_rd_data_valid <= 1'b1;
                void'(rd_due_q.pop_front());
            end else begin
                app_rd_data_valid <= 1'b0;
            end
        end
    end
endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_if,
    output logic resetn
);
    initial begin
        clk_if = 1'b0;
        forever #10 clk_if = ~clk_if;  // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk_if);
        resetn <= 1'b1;
    end
endmodule

// ==== design/ddr_ctrl_top.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module ddr_ctrl_top (
    input  logic                       clk_if,
    input  logic                       resetn,
    input  ddr_ctrl_pkg::ddr_req_t     req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output ddr_ctrl_pkg::ddr_resp_t    resp,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output ddr_ctrl_pkg::app_cmd_t     app_cmd,
    output logic                       app_cmd_en,
    output logic [`DDR_ADDR_WIDTH-1:0] app_addr,
    input  logic                       app_cmd_ready,
    output logic [`DDR_DATA_WIDTH-1:0] app_wr_data,
    output logic                       app_wr_data_en,
    output logic [`DDR_STRB_WIDTH-1:0] app_wr_data_mask,
    input  logic                       app_wr_data_rdy,
    input  logic [`DDR_DATA_WIDTH-1:0] app_rd_data,
    input  logic                       app_rd_data_valid
);
    import ddr_ctrl_pkg::*;

    ddr_req_t head;
    logic     head_valid;
    logic     head_pop;
    ddr_tag_t tag;
    logic     tag_push;
    logic     tag_room;

    cmd_queue u_cmd_queue (
        .clk_if     (clk_if),
        .resetn     (resetn),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .head       (head),
        .head_valid (head_valid),
        .head_pop   (head_pop)
    );

    app_sequencer u_app_sequencer (
        .clk_if           (clk_if),
        .resetn           (resetn),
        .head             (head),
        .head_valid       (head_valid),
        .head_pop         (head_pop),
        .app_cmd          (app_cmd),
        .app_cmd_en       (app_cmd_en),
        .app_addr         (app_addr),
        .app_cmd_ready    (app_cmd_ready),
        .app_wr_data      (app_wr_data),
        .app_wr_data_en   (app_wr_data_en),
        .app_wr_data_mask (app_wr_data_mask),
        .app_wr_data_rdy  (app_wr_data_rdy),
        .tag              (tag),
        .tag_push         (tag_push),
        .tag_room         (tag_room)
    );

    read_return u_read_return (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .tag               (tag),
        .tag_push          (tag_push),
        .tag_room          (tag_room),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .resp              (resp),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready)
    );

endmodule

// ==== design/read_return.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module read_return (
    input  logic                       clk_if,
    input  logic                       resetn,
    input  ddr_ctrl_pkg::ddr_tag_t     tag,
    input  logic                       tag_push,
    output logic                       tag_room,
    input  logic [`DDR_DATA_WIDTH-1:0] app_rd_data,
    input  logic                       app_rd_data_valid,
    output ddr_ctrl_pkg::ddr_resp_t    resp,
    output logic                       resp_valid,
    input  logic                       resp_ready
);
    import ddr_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`RESP_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ddr_tag_t         tags  [`RESP_DEPTH];
    ddr_resp_t        resps [`RESP_DEPTH];
    logic [PTR_W-1:0] tag_wr_ptr;
    logic [PTR_W-1:0] tag_rd_ptr;
    logic [PTR_W-1:0] resp_wr_ptr;
    logic [PTR_W-1:0] resp_rd_ptr;
    logic [CNT_W-1:0] tag_cnt;
    logic [CNT_W-1:0] resp_cnt;
    logic [CNT_W-1:0] occupancy;
    logic             resp_pop;
    ddr_tag_t         oldest;
    ddr_resp_t        beat;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`RESP_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign oldest = tags[tag_rd_ptr];  // beats come back in command order
    assign beat   = '{id: oldest.id, data: app_rd_data, last: oldest.last};

    assign resp       = resps[resp_rd_ptr];
    assign resp_valid = resp_cnt != '0;
    assign resp_pop   = resp_valid && resp_ready;

    // reads in flight plus responses not yet taken
    assign occupancy = tag_cnt + resp_cnt;
    assign tag_room  = occupancy < CNT_W'(`RESP_DEPTH);

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            tag_wr_ptr  <= '0;
            tag_rd_ptr  <= '0;
            resp_wr_ptr <= '0;
            resp_rd_ptr <= '0;
            tag_cnt     <= '0;
            resp_cnt    <= '0;
        end else begin
            if (tag_push) begin
                tag_wr_ptr <= ptr_inc(tag_wr_ptr);
            end
            if (app_rd_data_valid) begin
                tag_rd_ptr  <= ptr_inc(tag_rd_ptr);
                resp_wr_ptr <= ptr_inc(resp_wr_ptr);
            end
            if (resp_pop) begin
                resp_rd_ptr <= ptr_inc(resp_rd_ptr);
            end
            tag_cnt  <= tag_cnt + CNT_W'(tag_push) - CNT_W'(app_rd_data_valid);
            resp_cnt <= resp_cnt + CNT_W'(app_rd_data_valid) - CNT_W'(resp_pop);
        end
    end

    always_ff @(posedge clk_if) begin
        if (tag_push) begin
            tags[tag_wr_ptr] <= tag;
        end
        if (app_rd_data_valid) begin
            resps[resp_wr_ptr] <= beat;
        end
    end

    // every beat belongs to a read the sequencer sent
    property p_beat_has_tag;
        @(posedge clk_if) disable iff (!resetn)
            app_rd_data_valid |-> tag_cnt != '0;
    endproperty

    a_beat_has_tag: assert property (p_beat_has_tag)
        else $error("read_return: read data with no outstanding tag");

endmodule

// ==== design/app_sequencer.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module app_sequencer (
    input  logic                       clk_if,
    input  logic                       resetn,
    input  ddr_ctrl_pkg::ddr_req_t     head,
    input  logic                       head_valid,
    output logic                       head_pop,
    output ddr_ctrl_pkg::app_cmd_t     app_cmd,
    output logic                       app_cmd_en,
    output logic [`DDR_ADDR_WIDTH-1:0] app_addr,
    input  logic                       app_cmd_ready,
    output logic [`DDR_DATA_WIDTH-1:0] app_wr_data,
    output logic                       app_wr_data_en,
    output logic [`DDR_STRB_WIDTH-1:0] app_wr_data_mask,
    input  logic                       app_wr_data_rdy,
    output ddr_ctrl_pkg::ddr_tag_t     tag,
    output logic                       tag_push,
    input  logic                       tag_room
);
    import ddr_ctrl_pkg::*;

    seq_state_t state;
    logic       is_read;
    logic       cmd_xfer;
    logic       data_xfer;
    logic       cmd_done;
    logic       data_done;

    assign is_read = head.op == OP_READ;

    // a read needs a slot in read_return first
    assign head_pop = state == ST_IDLE && head_valid && (!is_read || tag_room);

    assign cmd_xfer  = app_cmd_en && app_cmd_ready;
    assign data_xfer = app_wr_data_en && app_wr_data_rdy;
    assign cmd_done  = !app_cmd_en || app_cmd_ready;       // sent earlier or now
    assign data_done = !app_wr_data_en || app_wr_data_rdy;

    assign tag_push = state == ST_READ && cmd_xfer;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state          <= ST_IDLE;
            app_cmd_en     <= 1'b0;
            app_wr_data_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_pop) begin
                        app_cmd_en     <= 1'b1;
                        app_wr_data_en <= !is_read;
                        state          <= is_read ? ST_READ : ST_WRITE;
                    end
                end
                ST_READ: begin
                    // back to idle so more reads can go out
                    if (cmd_xfer) begin
                        app_cmd_en <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (cmd_xfer) begin
                        app_cmd_en <= 1'b0;
                    end
                    if (data_xfer) begin
                        app_wr_data_en <= 1'b0;
                    end
                    if (cmd_done && data_done) begin  // either order
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_if) begin
        if (head_pop) begin
            app_cmd          <= is_read ? APP_READ : APP_WRITE;
            app_addr         <= head.addr;
            app_wr_data      <= head.wdata;
            app_wr_data_mask <= ~head.strb;  // mask bit set drops the byte
            tag.id           <= head.id;
            tag.last         <= head.last;
        end
    end

    property p_cmd_stable;
        @(posedge clk_if) disable iff (!resetn)
            app_cmd_en && !app_cmd_ready |=> $stable(app_cmd) && $stable(app_addr);
    endproperty

    a_cmd_stable: assert property (p_cmd_stable)
        else $error("app_sequencer: command changed while stalled");

endmodule

// ==== design/cmd_queue.sv ====
`timescale 1ns/100ps
`include "ddr_ctrl_config.svh"

module cmd_queue (
    input  logic                   clk_if,
    input  logic                   resetn,
    input  ddr_ctrl_pkg::ddr_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output ddr_ctrl_pkg::ddr_req_t head,
    output logic                   head_valid,
    input  logic                   head_pop
);
    import ddr_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`CMD_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    ddr_req_t         entries [`CMD_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push       = req_valid && req_ready;
    assign count_next = count + CNT_W'(push) - CNT_W'(head_pop);

    assign head       = entries[rd_ptr];
    assign head_valid = count != '0;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            req_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (head_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count     <= count_next;
            req_ready <= count_next != CNT_W'(`CMD_DEPTH);  // registered, low in reset
        end
    end

    always_ff @(posedge clk_if) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

    // sequencer only pops what it was shown
    property p_no_pop_when_empty;
        @(posedge clk_if) disable iff (!resetn)
            head_pop |-> count != '0;
    endproperty

    a_no_pop_when_empty: assert property (p_no_pop_when_empty)
        else $error("cmd_queue: pop while empty");

endmodule

// ==== design/ddr_ctrl_pkg.sv ====
`include "ddr_ctrl_config.svh"

package ddr_ctrl_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } req_op_t;

    // codes as the memory IP decodes them
    typedef enum logic [`APP_CMD_WIDTH-1:0] {
        APP_WRITE = 0,
        APP_READ  = 1
    } app_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } seq_state_t;

    typedef struct packed {
        req_op_t                    op;
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_ADDR_WIDTH-1:0] addr;  // word address
        logic [`DDR_DATA_WIDTH-1:0] wdata;
        logic [`DDR_STRB_WIDTH-1:0] strb;
        logic                       last;
    } ddr_req_t;

    // kept per outstanding read
    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0] id;
        logic                     last;
    } ddr_tag_t;

    typedef struct packed {
        logic [`DDR_ID_WIDTH-1:0]   id;
        logic [`DDR_DATA_WIDTH-1:0] data;
        logic                       last;
    } ddr_resp_t;

endpackage

// ==== design/ddr_ctrl_config.svh ====
`ifndef DDR_CTRL_CONFIG_SVH
`define DDR_CTRL_CONFIG_SVH

// request and app data path
`define DDR_DATA_WIDTH 64
`define DDR_STRB_WIDTH (`DDR_DATA_WIDTH / 8)
`define DDR_ADDR_WIDTH 28
`define DDR_ID_WIDTH   4

// command field width on the IP side
`define APP_CMD_WIDTH 3

// entries
`define CMD_DEPTH  4
`define RESP_DEPTH 4

`endif
